//--- include/uart_dbg_macros.svh
// UART debug loader build constants
// Serial timing, buffer depth and memory size shared by RTL and testbench

`ifndef UART_DBG_MACROS_SVH
`define UART_DBG_MACROS_SVH

////////////////////////////////////////////////////////////
// Serial line
////////////////////////////////////////////////////////////

// Clock cycles per serial bit
`define UART_CLKS_PER_BIT 8

////////////////////////////////////////////////////////////
// Buffering and storage
////////////////////////////////////////////////////////////

`define DBG_FIFO_DEPTH 16
`define DBG_MEM_DEPTH  256

`endif

//--- source/uart_pkg.sv
// UART line-level types
// Payload byte and the bit-level states of receiver and transmitter

package uart_pkg;

  typedef logic [7:0] byte_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

endpackage

//--- source/dbg_pkg.sv
// Debug protocol types
// Command and reply codes, transfer fields and engine states

`include "uart_dbg_macros.svh"

package dbg_pkg;

  // Byte codes seen on the serial line
  typedef enum logic [7:0] {
    CODE_EOT  = 8'h04,
    CODE_ACK  = 8'h06,
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12
  } cmd_e;

  typedef logic [$clog2(`DBG_MEM_DEPTH)-1:0] mem_addr_t;
  typedef logic [15:0] len_t;

  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_ADDR,
    ENG_LEN,
    ENG_ACK,
    ENG_DATA,
    ENG_EOT
  } eng_state_e;

endpackage

//--- source/uart_rx.sv
// 8N1 UART receiver
// Samples each bit at mid-period and strobes the byte at the stop-bit midpoint

`include "uart_dbg_macros.svh"

module uart_rx (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            uart_rx_i,
  output uart_pkg::byte_t rx_data_o,
  output logic            rx_valid_o
);
  import uart_pkg::*;

  localparam int CPB   = `UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CPB);

  logic [1:0]       sync_q;
  logic             rx_bit;
  rx_state_e        state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  byte_t            shift_q;
  logic             half_end;
  logic             bit_end;

  assign rx_bit    = sync_q[1];
  assign half_end  = (cnt_q == CNT_W'(CPB / 2 - 1));
  assign bit_end   = (cnt_q == CNT_W'(CPB - 1));
  assign rx_data_o = shift_q;

  // Two-flop synchronizer, idles high like the line
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], uart_rx_i};
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= RX_IDLE;
      cnt_q      <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (!rx_bit) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          cnt_q <= cnt_q + 1'b1;
          // Glitch shorter than half a bit goes back to idle
          if (half_end) begin
            cnt_q   <= '0;
            state_q <= rx_bit ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          cnt_q <= cnt_q + 1'b1;
          if (bit_end) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          cnt_q <= cnt_q + 1'b1;
          if (bit_end) begin
            // Framing error drops the byte
            rx_valid_o <= rx_bit;
            state_q    <= RX_IDLE;
          end
        end
        default: begin
          state_q <= RX_IDLE;
        end
      endcase
    end
  end

  // LSB first, so shift in from the top
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && bit_end) begin
      shift_q <= {rx_bit, shift_q[7:1]};
    end
  end

endmodule

//--- source/byte_fifo.sv
// Synchronous first-word-fall-through byte FIFO
// Head is visible on data_o whenever the FIFO is not empty

`include "uart_dbg_macros.svh"

module byte_fifo #(
  parameter int DEPTH = `DBG_FIFO_DEPTH
) (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            push_i,
  input  uart_pkg::byte_t data_i,
  input  logic            pop_i,
  output uart_pkg::byte_t data_o,
  output logic            full_o,
  output logic            empty_o
);
  import uart_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  byte_t            mem_q [DEPTH];
  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem_q[rptr_q];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == PTR_W'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == PTR_W'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wptr_q] <= data_i;
    end
  end

endmodule

//--- source/uart_tx.sv
// 8N1 UART transmitter
// Pops a byte from the transmit FIFO and shifts it out LSB first

`include "uart_dbg_macros.svh"

module uart_tx (
  input  logic            clk,
  input  logic            arst_n_i,
  input  uart_pkg::byte_t tx_data_i,
  input  logic            tx_pending_i,
  output logic            tx_pop_o,
  output logic            uart_tx_o
);
  import uart_pkg::*;

  localparam int CPB   = `UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CPB);

  tx_state_e        state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  byte_t            shift_q;
  logic             bit_end;
  logic             shift_en;

  assign bit_end  = (cnt_q == CNT_W'(CPB - 1));
  assign shift_en = bit_end && (state_q == TX_START || state_q == TX_DATA);

  // Next byte is taken at the end of the stop bit, so frames run back to back
  assign tx_pop_o = tx_pending_i &&
                    (state_q == TX_IDLE || (state_q == TX_STOP && bit_end));

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= TX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      uart_tx_o <= 1'b1;
    end else begin
      cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
      case (state_q)
        TX_IDLE: begin
          cnt_q <= '0;
          if (tx_pop_o) begin
            state_q   <= TX_START;
            uart_tx_o <= 1'b0;
          end
        end
        TX_START: begin
          if (bit_end) begin
            state_q   <= TX_DATA;
            bit_idx_q <= '0;
            uart_tx_o <= shift_q[0];
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q   <= TX_STOP;
              uart_tx_o <= 1'b1;
            end else begin
              uart_tx_o <= shift_q[0];
            end
          end
        end
        TX_STOP: begin
          if (bit_end) begin
            state_q   <= tx_pop_o ? TX_START : TX_IDLE;
            uart_tx_o <= !tx_pop_o;
          end
        end
        default: begin
          state_q <= TX_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (tx_pop_o) begin
      shift_q <= tx_data_i;
    end else if (shift_en) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

endmodule

//--- source/dbg_engine.sv
// Debug command engine
// Decodes ACK, read and write commands and moves bytes between FIFOs and memory

module dbg_engine (
  input  logic               clk,
  input  logic               arst_n_i,
  // Receive FIFO
  input  uart_pkg::byte_t    rx_data_i,
  input  logic               rx_empty_i,
  output logic               rx_pop_o,
  // Transmit FIFO
  output uart_pkg::byte_t    tx_data_o,
  output logic               tx_push_o,
  input  logic               tx_full_i,
  // Memory port
  output logic               mem_req_o,
  output logic               mem_we_o,
  output dbg_pkg::mem_addr_t mem_addr_o,
  output uart_pkg::byte_t    mem_wdata_o,
  input  uart_pkg::byte_t    mem_rdata_i
);
  import dbg_pkg::*;

  eng_state_e state_q;
  logic       is_write_q;
  logic [2:0] cnt_q;
  mem_addr_t  addr_q;
  len_t       len_q;
  logic       rd_pend_q;

  ////////////////////////////////////////////////////////////
  // Strobes and data paths
  ////////////////////////////////////////////////////////////

  always_comb begin
    rx_pop_o    = 1'b0;
    tx_push_o   = 1'b0;
    tx_data_o   = CODE_ACK;
    mem_req_o   = 1'b0;
    mem_we_o    = is_write_q;
    mem_addr_o  = addr_q;
    mem_wdata_o = rx_data_i;
    case (state_q)
      ENG_IDLE: begin
        if (!rx_empty_i) begin
          if (rx_data_i == CODE_ACK) begin
            // Challenge waits in the FIFO until the reply fits
            rx_pop_o  = !tx_full_i;
            tx_push_o = !tx_full_i;
          end else begin
            rx_pop_o = 1'b1;
          end
        end
      end
      ENG_ADDR, ENG_LEN: begin
        rx_pop_o = !rx_empty_i;
      end
      ENG_ACK: begin
        tx_push_o = !tx_full_i;
      end
      ENG_DATA: begin
        if (len_q != '0) begin
          if (is_write_q) begin
            rx_pop_o  = !rx_empty_i;
            mem_req_o = !rx_empty_i;
          end else if (!rd_pend_q) begin
            mem_req_o = 1'b1;
          end else begin
            // Read data stays on the memory output until the next request
            tx_push_o = !tx_full_i;
            tx_data_o = mem_rdata_i;
          end
        end
      end
      ENG_EOT: begin
        tx_push_o = !tx_full_i;
        tx_data_o = CODE_EOT;
      end
      default: begin
        rx_pop_o = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Command FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= ENG_IDLE;
      is_write_q <= 1'b0;
      cnt_q      <= '0;
      addr_q     <= '0;
      len_q      <= '0;
      rd_pend_q  <= 1'b0;
    end else begin
      case (state_q)
        ENG_IDLE: begin
          if (rx_pop_o && (rx_data_i == CMD_READ || rx_data_i == CMD_WRITE)) begin
            is_write_q <= (rx_data_i == CMD_WRITE);
            cnt_q      <= '0;
            state_q    <= ENG_ADDR;
          end
        end
        ENG_ADDR: begin
          // Eight address bytes, only the lowest one is kept
          if (rx_pop_o) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == 3'd0) begin
              addr_q <= mem_addr_t'(rx_data_i);
            end
            if (cnt_q == 3'd7) begin
              state_q <= ENG_LEN;
            end
          end
        end
        ENG_LEN: begin
          if (rx_pop_o) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == 3'd0) begin
              len_q[7:0] <= rx_data_i;
            end
            if (cnt_q == 3'd1) begin
              len_q[15:8] <= rx_data_i;
            end
            if (cnt_q == 3'd7) begin
              state_q <= ENG_ACK;
            end
          end
        end
        ENG_ACK: begin
          if (tx_push_o) begin
            rd_pend_q <= 1'b0;
            state_q   <= ENG_DATA;
          end
        end
        ENG_DATA: begin
          if (len_q == '0) begin
            state_q <= ENG_EOT;
          end else if (is_write_q) begin
            if (rx_pop_o) begin
              addr_q <= addr_q + 1'b1;
              len_q  <= len_q - 1'b1;
            end
          end else if (!rd_pend_q) begin
            rd_pend_q <= 1'b1;
          end else if (tx_push_o) begin
            rd_pend_q <= 1'b0;
            addr_q    <= addr_q + 1'b1;
            len_q     <= len_q - 1'b1;
          end
        end
        ENG_EOT: begin
          if (tx_push_o) begin
            state_q <= ENG_IDLE;
          end
        end
        default: begin
          state_q <= ENG_IDLE;
        end
      endcase
    end
  end

endmodule

//--- source/dbg_mem.sv
// Byte-wide debug memory
// Single read/write port with a registered read

`include "uart_dbg_macros.svh"

module dbg_mem (
  input  logic               clk,
  input  logic               mem_req_i,
  input  logic               mem_we_i,
  input  dbg_pkg::mem_addr_t mem_addr_i,
  input  uart_pkg::byte_t    mem_wdata_i,
  output uart_pkg::byte_t    mem_rdata_o
);
  import uart_pkg::*;

  byte_t mem_q [`DBG_MEM_DEPTH];

  // Read data holds until the next read request
  always_ff @(posedge clk) begin
    if (mem_req_i) begin
      if (mem_we_i) begin
        mem_q[mem_addr_i] <= mem_wdata_i;
      end else begin
        mem_rdata_o <= mem_q[mem_addr_i];
      end
    end
  end

endmodule

//--- source/uart_dbg_top.sv
// UART debug loader top level
// Receiver, byte FIFOs, command engine, memory and transmitter

`include "uart_dbg_macros.svh"

module uart_dbg_top (
  input  logic clk,
  input  logic arst_n_i,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  output logic rx_overrun_o
);
  import uart_pkg::*;
  import dbg_pkg::*;

  byte_t     rx_data;
  logic      rx_valid;
  byte_t     rx_head;
  logic      rx_pop;
  logic      rx_full;
  logic      rx_empty;
  byte_t     tx_data;
  logic      tx_push;
  logic      tx_full;
  logic      tx_empty;
  byte_t     tx_head;
  logic      tx_pop;
  logic      mem_req;
  logic      mem_we;
  mem_addr_t mem_addr;
  byte_t     mem_wdata;
  byte_t     mem_rdata;

  uart_rx u_uart_rx (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .uart_rx_i  (uart_rx_i),
    .rx_data_o  (rx_data),
    .rx_valid_o (rx_valid)
  );

  byte_fifo #(
    .DEPTH (`DBG_FIFO_DEPTH)
  ) u_rx_fifo (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .push_i   (rx_valid),
    .data_i   (rx_data),
    .pop_i    (rx_pop),
    .data_o   (rx_head),
    .full_o   (rx_full),
    .empty_o  (rx_empty)
  );

  // Sticky until reset, a byte arrived with nowhere to go
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_overrun_o <= 1'b0;
    end else if (rx_valid && rx_full) begin
      rx_overrun_o <= 1'b1;
    end
  end

  dbg_engine u_dbg_engine (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .rx_data_i   (rx_head),
    .rx_empty_i  (rx_empty),
    .rx_pop_o    (rx_pop),
    .tx_data_o   (tx_data),
    .tx_push_o   (tx_push),
    .tx_full_i   (tx_full),
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata)
  );

  dbg_mem u_dbg_mem (
    .clk         (clk),
    .mem_req_i   (mem_req),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_rdata_o (mem_rdata)
  );

  byte_fifo #(
    .DEPTH (`DBG_FIFO_DEPTH)
  ) u_tx_fifo (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .push_i   (tx_push),
    .data_i   (tx_data),
    .pop_i    (tx_pop),
    .data_o   (tx_head),
    .full_o   (tx_full),
    .empty_o  (tx_empty)
  );

  uart_tx u_uart_tx (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .tx_data_i    (tx_head),
    .tx_pending_i (!tx_empty),
    .tx_pop_o     (tx_pop),
    .uart_tx_o    (uart_tx_o)
  );

endmodule

//--- dv/tb_clk_gen.sv
// Testbench clock and reset
// 40 ns clock, reset held low for the first 16 rising edges

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_NS     = 20;
  localparam int RST_CYCLES  = 16;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_NS) clk_o = ~clk_o;
    end
  end

  // Release lands off the edge like the rest of the stimulus
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2;
    arst_n_o = 1'b1;
  end

endmodule

//--- dv/tb_uart_dbg.sv
// UART debug loader testbench
// Directed tests over the serial line, checked against a byte model of the memory

`include "uart_dbg_macros.svh"

module tb_uart_dbg;
  timeunit 1ns;
  timeprecision 100ps;

  import uart_pkg::*;
  import dbg_pkg::*;

  localparam int CPB    = `UART_CLKS_PER_BIT;
  localparam int CLK_NS = 40;
  // Frames of all tests plus one quiet gap of two frames per test
  localparam int FRAME_CNT = 179 + 2 * 5;
  localparam longint WATCHDOG_NS = longint'(FRAME_CNT) * 10 * CPB * CLK_NS * 2;

  logic  clk;
  logic  arst_n;
  logic  uart_rx_i;
  logic  uart_tx_o;
  logic  rx_overrun_o;

  byte_t model_mem [`DBG_MEM_DEPTH];
  byte_t payload [16];
  byte_t tx_q [$];
  logic  frame_busy;
  int    err_cnt;
  int    tests_passed;
  int    tests_failed;

  tb_clk_gen u_tb_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  uart_dbg_top u_uart_dbg_top (
    .clk          (clk),
    .arst_n_i     (arst_n),
    .uart_rx_i    (uart_rx_i),
    .uart_tx_o    (uart_tx_o),
    .rx_overrun_o (rx_overrun_o)
  );

  ////////////////////////////////////////////////////////////
  // Serial line driver and monitor
  ////////////////////////////////////////////////////////////

  task automatic drive_bit(input logic b);
    uart_rx_i = b;
    repeat (CPB) @(posedge clk);
    #2;
  endtask

  task automatic send_byte(input byte_t b);
    @(posedge clk);
    #2;
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(1'b1);
  endtask

  // Line changes on the rising edge, so it is sampled on the falling one
  task automatic capture_frame();
    byte_t b;
    @(negedge clk);
    while (uart_tx_o) begin
      @(negedge clk);
    end
    frame_busy = 1'b1;
    repeat (CPB / 2) @(negedge clk);
    if (uart_tx_o) begin
      $display("Error at %0t: start bit on uart_tx_o ended before mid-bit", $time);
      err_cnt++;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (CPB) @(negedge clk);
      b[i] = uart_tx_o;
    end
    repeat (CPB) @(negedge clk);
    if (!uart_tx_o) begin
      $display("Error at %0t: stop bit on uart_tx_o was low", $time);
      err_cnt++;
    end else begin
      tx_q.push_back(b);
    end
    frame_busy = 1'b0;
  endtask

  // A frame already under way is allowed to finish past the limit
  task automatic recv_byte(output byte_t b, output logic ok);
    int waited;
    waited = 0;
    ok     = 1'b0;
    b      = '0;
    while (tx_q.size() == 0 && (waited < 40 * CPB || frame_busy)) begin
      @(negedge clk);
      waited++;
    end
    if (tx_q.size() != 0) begin
      b  = tx_q.pop_front();
      ok = 1'b1;
    end else begin
      $display("Error at %0t: no start bit on uart_tx_o within 40 bit times", $time);
      err_cnt++;
    end
  endtask

  task automatic expect_byte(input byte_t exp);
    byte_t got;
    logic  ok;
    recv_byte(got, ok);
    if (ok && got !== exp) begin
      $display("Mismatch at %0t: uart_tx_o expected 8'h%02h, got 8'h%02h",
               $time, exp, got);
      err_cnt++;
    end
  endtask

  task automatic expect_quiet();
    repeat (20 * CPB) @(negedge clk);
    if (tx_q.size() != 0 || frame_busy) begin
      $display("Error at %0t: unexpected extra byte on uart_tx_o", $time);
      err_cnt++;
      tx_q.delete();
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, got);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Protocol commands
  ////////////////////////////////////////////////////////////

  // Command byte followed by 8-byte little-endian address and length
  task automatic send_header(input byte_t cmd, input logic [63:0] addr,
                             input logic [63:0] len);
    send_byte(cmd);
    for (int i = 0; i < 8; i++) begin
      send_byte(addr[8*i +: 8]);
    end
    for (int i = 0; i < 8; i++) begin
      send_byte(len[8*i +: 8]);
    end
  endtask

  task automatic write_mem(input logic [63:0] addr, input int len);
    logic [7:0] idx;
    send_header(CMD_WRITE, addr, 64'(len));
    for (int i = 0; i < len; i++) begin
      send_byte(payload[i]);
      idx = addr[7:0] + 8'(i);
      model_mem[idx] = payload[i];
    end
    expect_byte(CODE_ACK);
    expect_byte(CODE_EOT);
  endtask

  task automatic read_mem(input logic [63:0] addr, input int len);
    logic [7:0] idx;
    send_header(CMD_READ, addr, 64'(len));
    expect_byte(CODE_ACK);
    for (int i = 0; i < len; i++) begin
      idx = addr[7:0] + 8'(i);
      expect_byte(model_mem[idx]);
    end
    expect_byte(CODE_EOT);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_state_test();
    int e0;
    e0 = err_cnt;
    check_level("uart_tx_o", uart_tx_o, 1'b1);
    check_level("rx_overrun_o", rx_overrun_o, 1'b0);
    send_byte(CODE_ACK);
    expect_byte(CODE_ACK);
    expect_quiet();
    finish_test("reset_state_test", e0);
  endtask

  task automatic write_read_test();
    int          e0;
    logic [63:0] addr;
    e0   = err_cnt;
    addr = 64'($urandom() & 32'hff);
    for (int i = 0; i < 12; i++) begin
      payload[i] = byte_t'($urandom());
    end
    write_mem(addr, 12);
    read_mem(addr, 12);
    expect_quiet();
    finish_test("write_read_test", e0);
  endtask

  // Bytes 3 to 5 of the write land at addresses 0 to 2
  task automatic addr_wrap_test();
    int e0;
    e0 = err_cnt;
    for (int i = 0; i < 6; i++) begin
      payload[i] = byte_t'($urandom());
    end
    write_mem(64'hfd, 6);
    read_mem(64'h00, 3);
    expect_quiet();
    finish_test("addr_wrap_test", e0);
  endtask

  task automatic addr_high_bytes_test();
    int          e0;
    logic [63:0] addr;
    e0 = err_cnt;
    addr = {$urandom() | 32'h0101_0101, $urandom() | 32'h0101_0101};
    addr[7:0] = 8'h40;
    for (int i = 0; i < 4; i++) begin
      payload[i] = byte_t'($urandom());
    end
    write_mem(addr, 4);
    read_mem(64'h40, 4);
    expect_quiet();
    finish_test("addr_high_bytes_test", e0);
  endtask

  task automatic unknown_cmd_test();
    int e0;
    e0 = err_cnt;
    send_byte(8'h55);
    send_byte(CODE_ACK);
    expect_byte(CODE_ACK);
    write_mem(64'h10, 0);
    expect_quiet();
    check_level("rx_overrun_o", rx_overrun_o, 1'b0);
    finish_test("unknown_cmd_test", e0);
  endtask

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////

  initial begin
    wait (arst_n === 1'b1);
    forever begin
      capture_frame();
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Error at %0t: watchdog expired before the tests finished", $time);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    uart_rx_i    = 1'b1;
    frame_busy   = 1'b0;
    err_cnt      = 0;
    tests_passed = 0;
    tests_failed = 0;
    void'($urandom(32'hc63c_fa03));
    wait (arst_n === 1'b1);
    @(posedge clk);
    #2;
    reset_state_test();
    write_read_test();
    addr_wrap_test();
    addr_high_bytes_test();
    unknown_cmd_test();
    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+include
source/uart_pkg.sv
source/dbg_pkg.sv
source/uart_rx.sv
source/byte_fifo.sv
source/uart_tx.sv
source/dbg_engine.sv
source/dbg_mem.sv
source/uart_dbg_top.sv
dv/tb_clk_gen.sv
dv/tb_uart_dbg.sv
